// ==== video_pkg.sv ====
package video_pkg;

	// shared memory geometry
	// one word address covers the screen page bit plus the layout offset
	localparam int MEM_AW = 14;
	localparam int MEM_DW = 16;

	// offset inside one screen page
	localparam int ZX_OFS_W = 13;

	// one access to the shared word RAM
	// video slots always come through here as reads
	typedef struct packed {
		logic              we;
		logic [MEM_AW-1:0] addr;
		logic [MEM_DW-1:0] wdata;
	} mem_req_t;

	// owner of a memory slot
	// delayed by one cycle in the arbiter to steer read data
	typedef enum logic [1:0] {
		OWN_NONE  = 2'd0,
		OWN_VIDEO = 2'd1,
		OWN_CPU   = 2'd2
	} arb_owner_e;

	// one fetched video word with its tags
	// pos is the word pair index within the line, 0..15
	// attr set for attribute words, clear for pixel words
	typedef struct packed {
		logic [MEM_DW-1:0] data;
		logic              attr;
		logic [3:0]        pos;
	} vid_word_t;

endpackage

// ==== video_timing.sv ====
`timescale 1ns/1ns

module video_timing #(
	parameter int LINE_CLKS   = 96,
	parameter int FRAME_LINES = 200,
	parameter int PIX_LINES   = 192,
	parameter int FETCH_START = 8
) (
	input  logic clk,
	input  logic rst,
	output logic int_start,
	output logic line_start,
	output logic hsync_start,
	output logic fetch_win,
	output logic pix_line
);

	// fetch window length in clocks
	// 32 words plus 8 free slots for the cpu
	localparam int FETCH_LEN = 40;
	localparam int HW = $clog2(LINE_CLKS);
	localparam int VW = $clog2(FRAME_LINES);

	logic [HW-1:0] hcnt;
	logic [VW-1:0] vcnt;
	logic          hend;

	// last clock of a line
	assign hend = (hcnt == HW'(LINE_CLKS - 1));

	// horizontal counter wraps every line, vertical one every frame
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			hcnt <= '0;
			vcnt <= '0;
		end
		else if (hend)
		begin
			hcnt <= '0;
			if (vcnt == VW'(FRAME_LINES - 1))
				vcnt <= '0;
			else
				vcnt <= vcnt + 1'b1;
		end
		else
			hcnt <= hcnt + 1'b1;
	end

	// strobes decoded straight from the counters
	assign line_start  = (hcnt == '0);
	assign int_start   = line_start && (vcnt == '0);
	assign hsync_start = (hcnt == HW'(LINE_CLKS - 8));

	// only visible pixel lines fetch
	assign pix_line  = (vcnt < VW'(PIX_LINES));
	assign fetch_win = pix_line
		&& (hcnt >= HW'(FETCH_START))
		&& (hcnt < HW'(FETCH_START + FETCH_LEN));

endmodule

// ==== video_addrgen.sv ====
`timescale 1ns/1ns

module video_addrgen
	import video_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              int_start,
	input  logic              video_next,
	input  logic              scr_page,
	output logic [MEM_AW-1:0] video_addr
);

	// attribute area sits right after the 6k pixel area
	localparam logic [ZX_OFS_W-1:0] ATTR_BASE = ZX_OFS_W'(6144);

	// frame counter layout
	// bit 0 attribute or pixel
	// bits 4..1 word within the line
	// bits 12..5 screen line
	logic [ZX_OFS_W-1:0] zxcnt;

	logic [7:0]          line;
	logic [3:0]          word;
	logic [ZX_OFS_W-1:0] pix_ofs;
	logic [ZX_OFS_W-1:0] attr_ofs;
	logic [ZX_OFS_W-1:0] ofs;

	// restart at the frame, one step per granted word
	always_ff @(posedge clk)
	begin
		if (rst)
			zxcnt <= '0;
		else if (int_start)
			zxcnt <= '0;
		else if (video_next)
			zxcnt <= zxcnt + 1'b1;
	end

	assign line = zxcnt[12:5];
	assign word = zxcnt[4:1];

	// zx pixel layout
	// third of screen, then scanline in char, then char row
	assign pix_ofs = {1'b0, line[7:6], line[2:0], line[5:3], word};

	// one attribute row per 8 scanlines, 16 words wide here
	assign attr_ofs = ATTR_BASE + {4'b0000, line[7:3], word};

	// odd counter values are attribute slots
	assign ofs = zxcnt[0] ? attr_ofs : pix_ofs;

	// page bit on top of the offset
	assign video_addr = {scr_page, ofs};

endmodule

// ==== video_fetch.sv ====
`timescale 1ns/1ns

module video_fetch
	import video_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              line_start,
	input  logic              fetch_win,
	input  logic              video_next,
	input  logic [MEM_DW-1:0] mem_rdata,
	input  arb_owner_e        owner_d,
	output logic              video_req,
	output vid_word_t         vid_out,
	output logic              vid_valid
);

	// 16 pixel words and 16 attribute words per line
	localparam logic [5:0] LINE_WORDS = 6'd32;

	// grants seen on the current line
	logic [5:0] gcnt;

	// tags captured when the slot is granted
	logic       attr_q;
	logic [3:0] pos_q;

	always_ff @(posedge clk)
	begin
		if (rst)
			gcnt <= '0;
		else if (line_start)
			gcnt <= '0;
		else if (video_next)
			gcnt <= gcnt + 1'b1;
	end

	// ask only inside the window until the line is complete
	assign video_req = fetch_win && (gcnt < LINE_WORDS);

	// even grants are pixels, odd ones attributes
	always_ff @(posedge clk)
	begin
		if (video_next)
		begin
			attr_q <= gcnt[0];
			pos_q  <= gcnt[4:1];
		end
	end

	// ram data lands the cycle after the grant
	assign vid_out   = '{data: mem_rdata, attr: attr_q, pos: pos_q};
	assign vid_valid = (owner_d == OWN_VIDEO);

endmodule

// ==== video_mem.sv ====
`timescale 1ns/1ns

module video_mem
	import video_pkg::*;
(
	input  logic              clk,
	input  logic              mem_en,
	input  mem_req_t          mem_req,
	output logic [MEM_DW-1:0] mem_rdata
);

	// one word per address, whole address space
	logic [MEM_DW-1:0] ram [2**MEM_AW];

	// single port
	// write stores, read registers, one cycle latency
	always_ff @(posedge clk)
	begin
		if (mem_en)
		begin
			if (mem_req.we)
				ram[mem_req.addr] <= mem_req.wdata;
			else
				mem_rdata <= ram[mem_req.addr];
		end
	end

endmodule

// ==== mem_arbiter.sv ====
`timescale 1ns/1ns

module mem_arbiter
	import video_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              video_req,
	input  logic [MEM_AW-1:0] video_addr,
	input  logic              cpu_req,
	input  mem_req_t          cpu_cmd,
	output logic              video_next,
	output logic              cpu_ack,
	output logic              mem_en,
	output mem_req_t          mem_req,
	output arb_owner_e        owner_d,
	output logic [MEM_DW-1:0] cpu_rdata,
	output logic              cpu_rvalid,
	input  logic [MEM_DW-1:0] mem_rdata
);

	arb_owner_e owner;

	// fixed priority, video first
	always_comb
	begin
		if (video_req)
			owner = OWN_VIDEO;
		else if (cpu_req)
			owner = OWN_CPU;
		else
			owner = OWN_NONE;
	end

	// grants in the same cycle as the request
	assign video_next = (owner == OWN_VIDEO);
	assign cpu_ack    = (owner == OWN_CPU);
	assign mem_en     = (owner != OWN_NONE);

	// memory request mux
	// video slots are plain reads
	always_comb
	begin
		mem_req = '0;
		unique case (owner)
			OWN_VIDEO: mem_req.addr = video_addr;
			OWN_CPU:   mem_req      = cpu_cmd;
			default:   mem_req      = '0;
		endcase
	end

	// who gets the read data next cycle
	// cpu writes return nothing, so they leave no owner behind
	always_ff @(posedge clk)
	begin
		if (rst)
			owner_d <= OWN_NONE;
		else if ((owner == OWN_CPU) && cpu_cmd.we)
			owner_d <= OWN_NONE;
		else
			owner_d <= owner;
	end

	assign cpu_rdata  = mem_rdata;
	assign cpu_rvalid = (owner_d == OWN_CPU);

endmodule

// ==== video_top.sv ====
`timescale 1ns/1ns

module video_top
	import video_pkg::*;
#(
	parameter int LINE_CLKS   = 96,
	parameter int FRAME_LINES = 200,
	parameter int PIX_LINES   = 192,
	parameter int FETCH_START = 8
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              scr_page,
	input  logic              cpu_req,
	input  mem_req_t          cpu_cmd,
	output logic              cpu_ack,
	output logic [MEM_DW-1:0] cpu_rdata,
	output logic              cpu_rvalid,
	output vid_word_t         vid_out,
	output logic              vid_valid,
	output logic              int_start,
	output logic              line_start
);

	// raster to fetch
	logic              fetch_win;
	// fetch and address generator to arbiter
	logic              video_req;
	logic              video_next;
	logic [MEM_AW-1:0] video_addr;
	// arbiter to ram and back
	mem_req_t          mem_req;
	logic              mem_en;
	logic [MEM_DW-1:0] mem_rdata;
	arb_owner_e        owner_d;

	// hsync and pixel line flag are not needed by the zx fetch path
	video_timing #(
		.LINE_CLKS  (LINE_CLKS),
		.FRAME_LINES(FRAME_LINES),
		.PIX_LINES  (PIX_LINES),
		.FETCH_START(FETCH_START)
	) u_timing (
		.clk        (clk),
		.rst        (rst),
		.int_start  (int_start),
		.line_start (line_start),
		.hsync_start(),
		.fetch_win  (fetch_win),
		.pix_line   ()
	);

	video_addrgen u_addrgen (
		.clk       (clk),
		.rst       (rst),
		.int_start (int_start),
		.video_next(video_next),
		.scr_page  (scr_page),
		.video_addr(video_addr)
	);

	video_fetch u_fetch (
		.clk       (clk),
		.rst       (rst),
		.line_start(line_start),
		.fetch_win (fetch_win),
		.video_next(video_next),
		.mem_rdata (mem_rdata),
		.owner_d   (owner_d),
		.video_req (video_req),
		.vid_out   (vid_out),
		.vid_valid (vid_valid)
	);

	mem_arbiter u_arbiter (
		.clk       (clk),
		.rst       (rst),
		.video_req (video_req),
		.video_addr(video_addr),
		.cpu_req   (cpu_req),
		.cpu_cmd   (cpu_cmd),
		.video_next(video_next),
		.cpu_ack   (cpu_ack),
		.mem_en    (mem_en),
		.mem_req   (mem_req),
		.owner_d   (owner_d),
		.cpu_rdata (cpu_rdata),
		.cpu_rvalid(cpu_rvalid),
		.mem_rdata (mem_rdata)
	);

	video_mem u_mem (
		.clk      (clk),
		.mem_en   (mem_en),
		.mem_req  (mem_req),
		.mem_rdata(mem_rdata)
	);

endmodule

// ==== video_props.sv ====
`timescale 1ns/1ns

module video_props
	import video_pkg::*;
#(
	parameter int LINE_CLKS = 96
) (
	input logic     clk,
	input logic     rst,
	input logic     video_next,
	input logic     cpu_req,
	input logic     cpu_ack,
	input mem_req_t cpu_cmd,
	input logic     cpu_rvalid,
	input logic     fetch_win,
	input logic     vid_valid,
	input logic     line_start
);

	// failures seen so far
	int fail_count = 0;

	// no video burst outside the window, so the cpu is served at once
	cpu_outside_window: assert property (@(posedge clk) disable iff (rst)
		(cpu_req && !fetch_win) |-> cpu_ack)
	else
	begin
		fail_count++;
		$error("cpu request not granted outside the fetch window");
	end

	// read data one cycle after a read ack, and never otherwise
	rvalid_after_ack: assert property (@(posedge clk) disable iff (rst)
		cpu_rvalid == $past(cpu_ack && !cpu_cmd.we))
	else
	begin
		fail_count++;
		$error("cpu_rvalid does not follow a read ack by one cycle");
	end

	video_in_window: assert property (@(posedge clk) disable iff (rst)
		video_next |-> fetch_win)
	else
	begin
		fail_count++;
		$error("video grant outside the fetch window");
	end

	// word shows up the cycle after its grant
	vid_after_grant: assert property (@(posedge clk) disable iff (rst)
		video_next |=> vid_valid)
	else
	begin
		fail_count++;
		$error("vid_valid missing after a video grant");
	end

	line_period: assert property (@(posedge clk) disable iff (rst)
		line_start |-> ##LINE_CLKS line_start)
	else
	begin
		fail_count++;
		$error("line_start period is not LINE_CLKS");
	end

endmodule

// on the top, where arbiter and fetch nets meet
bind video_top video_props #(
	.LINE_CLKS(LINE_CLKS)
) u_props (
	.clk       (clk),
	.rst       (rst),
	.video_next(video_next),
	.cpu_req   (cpu_req),
	.cpu_ack   (cpu_ack),
	.cpu_cmd   (cpu_cmd),
	.cpu_rvalid(cpu_rvalid),
	.fetch_win (fetch_win),
	.vid_valid (vid_valid),
	.line_start(line_start)
);

// ==== tb_video.sv ====
`timescale 1ns/1ns

module tb_video;
	import video_pkg::*;

	localparam int LINE_CLKS   = 96;
	localparam int FRAME_LINES = 200;
	localparam int PIX_LINES   = 192;
	localparam int FETCH_START = 8;
	localparam int FRAME_CLKS  = LINE_CLKS * FRAME_LINES;
	// 16 pixel words and 16 attribute words per line
	localparam int LINE_WORDS  = 32;
	// pixel area 0..3071 and attribute area 6144..6527, on both pages
	localparam int FILL_WORDS  = 2 * (3072 + 384);
	// fill with stalls, three frames of checks, then the load lines
	localparam int WATCHDOG_CLKS = 2 * FILL_WORDS + 3 * FRAME_CLKS + 8 * LINE_CLKS;

	logic              clk;
	logic              rst;
	logic              scr_page;
	logic              cpu_req;
	mem_req_t          cpu_cmd;
	logic              cpu_ack;
	logic [MEM_DW-1:0] cpu_rdata;
	logic              cpu_rvalid;
	vid_word_t         vid_out;
	logic              vid_valid;
	logic              int_start;
	logic              line_start;

	int seed = 56463;
	// last value written per address
	logic [MEM_DW-1:0] scratch [logic [MEM_AW-1:0]];

	video_top #(
		.LINE_CLKS  (LINE_CLKS),
		.FRAME_LINES(FRAME_LINES),
		.PIX_LINES  (PIX_LINES),
		.FETCH_START(FETCH_START)
	) u_video_top (
		.clk       (clk),
		.rst       (rst),
		.scr_page  (scr_page),
		.cpu_req   (cpu_req),
		.cpu_cmd   (cpu_cmd),
		.cpu_ack   (cpu_ack),
		.cpu_rdata (cpu_rdata),
		.cpu_rvalid(cpu_rvalid),
		.vid_out   (vid_out),
		.vid_valid (vid_valid),
		.int_start (int_start),
		.line_start(line_start)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic halt_run(input string reason);
		$display("%s", reason);
		$display("Regression failed");
		$fatal(1, "%s", reason);
	endtask

	task automatic report_mismatch(input string what, input int got, input int expected);
		$display("** Error at %0t ns: %s got %h expected %h", $time, what, got, expected);
		halt_run("stopping at the first mismatch");
	endtask

	// zx layout, memory holds its own address, page on bit 13
	function automatic logic [MEM_DW-1:0] expected_word(input logic page, input int line,
			input int pos, input logic attr);
		int ofs;
		if (attr)
			ofs = 6144 + (line / 8) * 16 + pos;
		else
			ofs = (line / 64) * 1024 + (line % 8) * 128 + ((line / 8) % 8) * 16 + pos;
		return MEM_DW'(page * 8192 + ofs);
	endfunction

	// hold the request until the arbiter grants it
	task automatic cpu_issue(input mem_req_t cmd);
		int waits;
		waits = 0;
		@(negedge clk);
		cpu_req = 1'b1;
		cpu_cmd = cmd;
		@(posedge clk);
		while (!cpu_ack)
		begin
			waits++;
			// at most one fetch burst in the way
			assert (waits <= LINE_WORDS)
			else
				halt_run("cpu request waited longer than one fetch burst");
			@(posedge clk);
		end
	endtask

	// request stays up so writes run back to back
	task automatic cpu_write(input logic [MEM_AW-1:0] addr, input logic [MEM_DW-1:0] data);
		cpu_issue('{we: 1'b1, addr: addr, wdata: data});
	endtask

	task automatic cpu_read(input logic [MEM_AW-1:0] addr, output logic [MEM_DW-1:0] data);
		cpu_issue('{we: 1'b0, addr: addr, wdata: '0});
		@(negedge clk);
		cpu_req = 1'b0;
		@(posedge clk);
		assert (cpu_rvalid)
		else
			halt_run("read data valid missing one cycle after the cpu ack");
		data = cpu_rdata;
	endtask

	task automatic cpu_release();
		@(negedge clk);
		cpu_req = 1'b0;
	endtask

	task automatic test_cpu_readback();
		logic [MEM_AW-1:0] addr;
		logic [MEM_DW-1:0] data;
		for (int i = 0; i < 32; i++)
		begin
			// narrow range so some addresses get overwritten
			addr = MEM_AW'(14'h3000 | ($random(seed) & 31));
			data = MEM_DW'($random(seed));
			cpu_write(addr, data);
			scratch[addr] = data;
		end
		foreach (scratch[a])
		begin
			cpu_read(a, data);
			assert (data === scratch[a])
			else
				report_mismatch("cpu readback", data, scratch[a]);
		end
	endtask

	task automatic fill_screens();
		for (int p = 0; p < 2; p++)
		begin
			for (int a = 0; a < 6528; a++)
			begin
				if (a < 3072 || a >= 6144)
					cpu_write(MEM_AW'(p * 8192 + a), MEM_DW'(p * 8192 + a));
			end
		end
		cpu_release();
	endtask

	// one whole frame of pixel lines, every word checked
	task automatic check_frame(input logic page);
		int line;
		int nwords;
		logic [MEM_DW-1:0] exp;
		@(negedge clk);
		scr_page = page;
		do
			@(posedge clk);
		while (!int_start);
		// frame strobe sits on clock 0 of line 0
		assert (line_start)
		else
			halt_run("frame strobe not on a line start");
		line = 0;
		nwords = 0;
		while (line < PIX_LINES)
		begin
			@(posedge clk);
			if (line_start)
			begin
				assert (nwords == LINE_WORDS)
				else
					report_mismatch("words per line", nwords, LINE_WORDS);
				assert (!int_start)
				else
					halt_run("frame strobe inside the visible lines");
				line++;
				nwords = 0;
			end
			if (vid_valid)
			begin
				// pixel word first, then its attribute
				assert (vid_out.attr == (nwords % 2) && vid_out.pos == nwords / 2)
				else
					report_mismatch("word tag", {vid_out.attr, vid_out.pos},
						(nwords % 2) * 16 + nwords / 2);
				exp = expected_word(page, line, nwords / 2, nwords % 2 == 1);
				assert (vid_out.data === exp)
				else
					report_mismatch("video word", vid_out.data, exp);
				nwords++;
			end
		end
	endtask

	task automatic cpu_traffic(input int count);
		logic [MEM_AW-1:0] addr;
		logic [MEM_DW-1:0] wdata;
		logic [MEM_DW-1:0] rdata;
		for (int i = 0; i < count; i++)
		begin
			// above the attribute area, never fetched
			addr = MEM_AW'(14'h1c00 + ($random(seed) & 255));
			wdata = MEM_DW'($random(seed));
			cpu_write(addr, wdata);
			cpu_read(addr, rdata);
			assert (rdata === wdata)
			else
				report_mismatch("read under load", rdata, wdata);
		end
	endtask

	task automatic watch_load_lines(input int nlines);
		int hpos;
		int line;
		int nwords;
		hpos = 0;
		line = 0;
		nwords = 0;
		while (line < nlines)
		begin
			@(posedge clk);
			if (line_start)
			begin
				assert (nwords == LINE_WORDS)
				else
					report_mismatch("words per line under load", nwords, LINE_WORDS);
				line++;
				nwords = 0;
				hpos = 0;
			end
			else
				hpos++;
			if (vid_valid)
				nwords++;
			// burst owns clocks FETCH_START..FETCH_START+31
			if (cpu_ack)
				assert (hpos < FETCH_START || hpos >= FETCH_START + LINE_WORDS)
				else
					halt_run("cpu granted a slot inside the video fetch burst");
		end
	endtask

	task automatic test_arbitration_load();
		@(negedge clk);
		scr_page = 1'b0;
		do
			@(posedge clk);
		while (!int_start);
		fork
			cpu_traffic(96);
			watch_load_lines(4);
		join
	endtask

	initial
	begin
		repeat (WATCHDOG_CLKS) @(posedge clk);
		halt_run($sformatf("watchdog expired, tests not done after %0d clocks", WATCHDOG_CLKS));
	end

	initial
	begin
		rst = 1'b1;
		scr_page = 1'b0;
		cpu_req = 1'b0;
		cpu_cmd = '0;
		repeat (10) @(negedge clk);
		rst = 1'b0;
		test_cpu_readback();
		fill_screens();
		check_frame(1'b0);
		check_frame(1'b1);
		test_arbitration_load();
		if (u_video_top.u_props.fail_count == 0)
		begin
			$display("Regression passed");
			$finish;
		end
		else
		begin
			$display("%0d concurrent assertion failures", u_video_top.u_props.fail_count);
			$display("Regression failed");
			$fatal(1, "concurrent assertions failed");
		end
	end

endmodule

// ==== compile.f ====
video_pkg.sv
video_timing.sv
video_addrgen.sv
video_fetch.sv
video_mem.sv
mem_arbiter.sv
video_top.sv
video_props.sv
tb_video.sv

// ==== Bender.yml ====
package:
  name: zx_video_fetch

sources:
  - video_pkg.sv
  - video_timing.sv
  - video_addrgen.sv
  - video_fetch.sv
  - video_mem.sv
  - mem_arbiter.sv
  - video_top.sv
  - target: test
    files:
      - video_props.sv
      - tb_video.sv
